// ==== src.f ====
+incdir+bench
hw/dct_pkg.sv
hw/dct_row_buffer.sv
hw/dct_butterfly_seq.sv
hw/dct_mac.sv
hw/dct_row_top.sv
bench/tb_dct_row.sv

// ==== Makefile ====
SIM  := obj_dir/Vtb_dct_row
SRCS := $(wildcard hw/*.sv bench/*.sv bench/*.svh)

.PHONY: run clean

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	! grep -q "CHECKS FAILED" sim.log
	grep -q "ALL CHECKS PASSED" sim.log

$(SIM): src.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_dct_row -f src.f

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_dct_model.svh ====
`ifndef TB_DCT_MODEL_SVH
`define TB_DCT_MODEL_SVH

// butterfly term i for output k, sums for even k and differences for odd k.
function automatic int fold_term(input int row [8], input int k, input int i);
  int mirror;
  mirror = dct_pkg::ROW_LEN - 1 - i;
  if (k % 2 == 0)
    return row[i] + row[mirror];
  else
    return row[i] - row[mirror];
endfunction

// full-precision dot product of the folded row with table row k.
function automatic int dot_row(input int row [8], input int k);
  int acc;
  int i;
  acc = 0;
  for (i = 0; i < dct_pkg::HALF_LEN; i++)
  begin
    acc = acc + fold_term(row, k, i) * int'(dct_pkg::COEF_TABLE[k][i]);
  end
  return acc;
endfunction

// add half an output step, then drop the fraction with an arithmetic shift.
function automatic int round_coef(input int acc);
  int half_step;
  half_step = 1 << (dct_pkg::COEF_FRACT_WIDTH - 1);
  return (acc + half_step) >>> dct_pkg::COEF_FRACT_WIDTH;
endfunction

// expected output value for coefficient k of one row.
function automatic int expected_coef(input int row [8], input int k);
  return round_coef(dot_row(row, k));
endfunction

`endif

// ==== bench/tb_dct_row.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dct_row;

logic                                     clk;
logic                                     rst;
logic                                     px_valid;
dct_pkg::px_t                             px_data;
logic                                     coef_valid;
dct_pkg::out_t                            coef_data;
logic [dct_pkg::IDX_WIDTH - 1 : 0]        coef_index;

int exp_data_q [$];
int exp_idx_q  [$];
int exp_cyc_q  [$];
int cyc        = 0;
int mon_row    [8];
int mon_cnt    = 0;
int check_cnt  = 0;
int err_cnt    = 0;
int extra_cnt  = 0;   // valid cycles with nothing expected.

`include "tb_dct_model.svh"

dct_row_top i_dut (
  .clk_i        ( clk        ),
  .rst_i        ( rst        ),
  .px_valid_i   ( px_valid   ),
  .px_data_i    ( px_data    ),
  .coef_valid_o ( coef_valid ),
  .coef_data_o  ( coef_data  ),
  .coef_index_o ( coef_index )
);

initial
begin
  clk = 1'b0;
  forever #20 clk = ~clk;
end

always @(posedge clk)
  cyc <= cyc + 1;

task automatic check_value(input string what, input logic signed [31:0] got,
                           input logic signed [31:0] exp);
  check_cnt++;
  if (got !== exp)
  begin
    err_cnt++;
    $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
  end
endtask

// outputs are sampled at the falling edge, half a cycle away from any change.
always @(negedge clk)
begin
  if (!rst && px_valid)
  begin
    mon_row[mon_cnt] = int'(px_data);
    mon_cnt++;
    if (mon_cnt == dct_pkg::ROW_LEN)
    begin
      // this pixel is taken at the next rising edge, number cyc + 1.
      for (int k = 0; k < dct_pkg::ROW_LEN; k++)
      begin
        exp_data_q.push_back(expected_coef(mon_row, k));
        exp_idx_q.push_back(k);
        exp_cyc_q.push_back(cyc + 1 + 5 + k);
      end
      mon_cnt = 0;
    end
  end
  if (coef_valid !== 1'b0)
  begin
    if (exp_data_q.size() == 0)
    begin
      extra_cnt++;
      $display("unexpected coefficient valid at %0t with nothing expected", $time);
    end
    else
    begin
      check_value("coef_data", 32'($signed(coef_data)), exp_data_q.pop_front());
      check_value("coef_index", 32'(coef_index), exp_idx_q.pop_front());
      check_value("valid cycle", cyc, exp_cyc_q.pop_front());
    end
  end
end

task automatic idle_cycle();
  @(posedge clk);
  px_valid <= 1'b0;
endtask

task automatic send_px(input int value);
  @(posedge clk);
  px_valid <= 1'b1;
  px_data  <= value[7:0];
endtask

task automatic send_row(input int row [8], input bit with_gaps);
  int i;
  int gap;
  for (i = 0; i < dct_pkg::ROW_LEN; i++)
  begin
    if (with_gaps)
    begin
      gap = int'($urandom_range(0, 3));
      repeat (gap) idle_cycle();
    end
    send_px(row[i]);
  end
endtask

task automatic random_row(output int row [8]);
  int i;
  for (i = 0; i < dct_pkg::ROW_LEN; i++)
    row[i] = int'($urandom_range(0, 255));
endtask

initial
begin
  int row [8];
  int i;
  int r;
  int wait_cnt;
  rst      = 1'b1;
  px_valid = 1'b0;
  px_data  = '0;
  void'($urandom(32'hff8d_08f7));
  repeat (2) @(posedge clk);
  rst <= 1'b0;
  repeat (6) idle_cycle();   // no output may show up before a full row.

  for (i = 0; i < 8; i++) row[i] = 0;
  send_row(row, 1'b0);
  for (i = 0; i < 8; i++) row[i] = 255;
  send_row(row, 1'b0);
  for (i = 0; i < 8; i++) row[i] = (i % 2 == 0) ? 0 : 255;
  send_row(row, 1'b0);
  for (i = 0; i < 8; i++) row[i] = i * 36;
  send_row(row, 1'b0);

  for (r = 0; r < 24; r++)
  begin
    random_row(row);
    send_row(row, 1'b0);
  end
  for (r = 0; r < 24; r++)
  begin
    random_row(row);
    send_row(row, 1'b1);
  end
  idle_cycle();

  wait_cnt = 0;
  while (exp_data_q.size() != 0 && wait_cnt < 200)
  begin
    @(posedge clk);
    wait_cnt++;
  end
  if (exp_data_q.size() != 0)
  begin
    err_cnt++;
    $display("timeout: %0d expected coefficients never came out", exp_data_q.size());
  end
  repeat (16) idle_cycle();   // any late valid now counts as unexpected.

  $display("checks: %0d, mismatches: %0d, unexpected valids: %0d",
           check_cnt, err_cnt, extra_cnt);
  if (err_cnt == 0 && extra_cnt == 0 && check_cnt > 0)
    $display("ALL CHECKS PASSED");
  else
    $display("CHECKS FAILED");
  $finish;
end

endmodule

`default_nettype wire

// ==== hw/dct_row_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dct_row_top (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              px_valid_i,
  input  dct_pkg::px_t                      px_data_i,
  output logic                              coef_valid_o,
  output dct_pkg::out_t                     coef_data_o,
  output logic [dct_pkg::IDX_WIDTH - 1 : 0] coef_index_o
);

logic                                        row_valid;
dct_pkg::px_t   [dct_pkg::ROW_LEN - 1 : 0]   row_px;
logic                                        opnd_valid;
dct_pkg::opnd_t [dct_pkg::HALF_LEN - 1 : 0]  opnd;
dct_pkg::coef_t [dct_pkg::HALF_LEN - 1 : 0]  coef;
logic [dct_pkg::IDX_WIDTH - 1 : 0]           opnd_index;

dct_row_buffer i_row_buffer (
  .clk_i        ( clk_i        ),
  .rst_i        ( rst_i        ),
  .px_valid_i   ( px_valid_i   ),
  .px_data_i    ( px_data_i    ),
  .row_valid_o  ( row_valid    ),
  .row_px_o     ( row_px       )
);

dct_butterfly_seq i_butterfly_seq (
  .clk_i        ( clk_i        ),
  .rst_i        ( rst_i        ),
  .row_valid_i  ( row_valid    ),
  .row_px_i     ( row_px       ),
  .opnd_valid_o ( opnd_valid   ),
  .opnd_o       ( opnd         ),
  .coef_o       ( coef         ),
  .opnd_index_o ( opnd_index   )
);

dct_mac i_mac (
  .clk_i        ( clk_i        ),
  .rst_i        ( rst_i        ),
  .opnd_valid_i ( opnd_valid   ),
  .opnd_i       ( opnd         ),
  .coef_i       ( coef         ),
  .opnd_index_i ( opnd_index   ),
  .coef_valid_o ( coef_valid_o ),
  .coef_data_o  ( coef_data_o  ),
  .coef_index_o ( coef_index_o )
);

endmodule

`default_nettype wire

// ==== hw/dct_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

module dct_mac (
  input  logic                                        clk_i,
  input  logic                                        rst_i,
  input  logic                                        opnd_valid_i,
  input  dct_pkg::opnd_t [dct_pkg::HALF_LEN - 1 : 0]  opnd_i,
  input  dct_pkg::coef_t [dct_pkg::HALF_LEN - 1 : 0]  coef_i,
  input  logic [dct_pkg::IDX_WIDTH - 1 : 0]           opnd_index_i,
  output logic                                        coef_valid_o,
  output dct_pkg::out_t                               coef_data_o,
  output logic [dct_pkg::IDX_WIDTH - 1 : 0]           coef_index_o
);

dct_pkg::prod_t                         prod_q [dct_pkg::HALF_LEN];
dct_pkg::acc_t                          pair_q [2];
dct_pkg::acc_t                          acc_sum;
logic [dct_pkg::MAC_LATENCY - 1 : 0]    valid_d;
logic [dct_pkg::MAC_LATENCY - 1 : 0][dct_pkg::IDX_WIDTH - 1 : 0] index_d;

// Stage 1 forms the four signed products.
always_ff @( posedge clk_i )
  for( int i = 0; i < dct_pkg::HALF_LEN; i++ )
    prod_q[i] <= dct_pkg::prod_t'( $signed( opnd_i[i] ) ) *
                 dct_pkg::prod_t'( $signed( coef_i[i] ) );

// Stage 2 forms the pair sums.
always_ff @( posedge clk_i )
  for( int j = 0; j < 2; j++ )
    pair_q[j] <= dct_pkg::acc_t'( prod_q[2 * j] ) + dct_pkg::acc_t'( prod_q[2 * j + 1] );

// Adding the bias and keeping the bits above the fraction is the same as
// (sum + 512) >>> 10 for every value the table can produce.
assign acc_sum = pair_q[0] + pair_q[1] + dct_pkg::ROUND_BIAS;

always_ff @( posedge clk_i )
  coef_data_o <= acc_sum[dct_pkg::COEF_FRACT_WIDTH +: dct_pkg::OUT_WIDTH];

// Valid and index ride alongside the data, one entry per stage.
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      valid_d <= '0;
      index_d <= '0;
    end
  else
    begin
      valid_d <= { valid_d[dct_pkg::MAC_LATENCY - 2 : 0], opnd_valid_i };
      index_d <= { index_d[dct_pkg::MAC_LATENCY - 2 : 0], opnd_index_i };
    end

assign coef_valid_o = valid_d[dct_pkg::MAC_LATENCY - 1];
assign coef_index_o = index_d[dct_pkg::MAC_LATENCY - 1];

// an unknown here means a valid reached the output without a full operand set.
coef_data_known : assert property (
  @( posedge clk_i ) disable iff ( rst_i )
  coef_valid_o |-> !$isunknown( coef_data_o )
);

endmodule

`default_nettype wire

// ==== hw/dct_butterfly_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module dct_butterfly_seq (
  input  logic                                        clk_i,
  input  logic                                        rst_i,
  input  logic                                        row_valid_i,
  input  dct_pkg::px_t  [dct_pkg::ROW_LEN - 1 : 0]    row_px_i,
  output logic                                        opnd_valid_o,
  output dct_pkg::opnd_t [dct_pkg::HALF_LEN - 1 : 0]  opnd_o,
  output dct_pkg::coef_t [dct_pkg::HALF_LEN - 1 : 0]  coef_o,
  output logic [dct_pkg::IDX_WIDTH - 1 : 0]           opnd_index_o
);

dct_pkg::opnd_t                    sum_q  [dct_pkg::HALF_LEN];
dct_pkg::opnd_t                    diff_q [dct_pkg::HALF_LEN];
logic [dct_pkg::IDX_WIDTH - 1 : 0] idx_cnt;
logic                              busy;

// Fold the row once per row, x_i against x_(7-i).
always_ff @( posedge clk_i )
  if( row_valid_i )
    for( int i = 0; i < dct_pkg::HALF_LEN; i++ )
      begin
        sum_q[i]  <= $signed( { 2'b00, row_px_i[i] } ) +
                     $signed( { 2'b00, row_px_i[dct_pkg::ROW_LEN - 1 - i] } );
        diff_q[i] <= $signed( { 2'b00, row_px_i[i] } ) -
                     $signed( { 2'b00, row_px_i[dct_pkg::ROW_LEN - 1 - i] } );
      end

// A new row may restart the counter on the cycle that issues index 7.
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      busy    <= 1'b0;
      idx_cnt <= '0;
    end
  else
    if( row_valid_i )
      begin
        busy    <= 1'b1;
        idx_cnt <= '0;
      end
    else
      if( busy )
        begin
          idx_cnt <= idx_cnt + 1'b1;
          if( &idx_cnt )
            busy <= 1'b0;   // last coefficient of the row issued.
        end

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      opnd_valid_o <= 1'b0;
      opnd_index_o <= '0;
    end
  else
    begin
      opnd_valid_o <= busy;
      if( busy )
        opnd_index_o <= idx_cnt;
    end

// even k takes the sums, odd k the differences.
always_ff @( posedge clk_i )
  if( busy )
    for( int i = 0; i < dct_pkg::HALF_LEN; i++ )
      begin
        opnd_o[i] <= idx_cnt[0] ? diff_q[i] : sum_q[i];
        coef_o[i] <= dct_pkg::COEF_TABLE[idx_cnt][i];
      end

row_not_while_busy : assert property (
  @( posedge clk_i ) disable iff ( rst_i )
  row_valid_i |-> ( !busy || ( &idx_cnt ) )
);

endmodule

`default_nettype wire

// ==== hw/dct_row_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dct_row_buffer (
  input  logic                                      clk_i,
  input  logic                                      rst_i,
  input  logic                                      px_valid_i,
  input  dct_pkg::px_t                              px_data_i,
  output logic                                      row_valid_o,
  output dct_pkg::px_t [dct_pkg::ROW_LEN - 1 : 0]   row_px_o
);

dct_pkg::px_t [dct_pkg::ROW_LEN - 1 : 0] half_q [2];
logic [dct_pkg::IDX_WIDTH - 1 : 0]       px_cnt;
logic                                    fill_sel;   // half currently being written.
logic                                    row_done;

// the eighth accepted pixel closes a row.
assign row_done = px_valid_i && ( &px_cnt );

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    px_cnt <= '0;
  else
    if( px_valid_i )
      px_cnt <= px_cnt + 1'b1;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    fill_sel <= 1'b0;
  else
    if( row_done )
      fill_sel <= !fill_sel;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    row_valid_o <= 1'b0;
  else
    row_valid_o <= row_done;

always_ff @( posedge clk_i )
  if( px_valid_i )
    half_q[fill_sel][px_cnt] <= px_data_i;

// The locked half stays put while the other one fills.
assign row_px_o = half_q[!fill_sel];

// a row takes eight accepted pixels, so two pulses can never touch.
row_valid_single : assert property (
  @( posedge clk_i ) disable iff ( rst_i )
  row_valid_o |=> !row_valid_o
);

endmodule

`default_nettype wire

// ==== hw/dct_pkg.sv ====
`default_nettype none

package dct_pkg;

  localparam int PX_WIDTH         = 8;
  localparam int ROW_LEN          = 8;
  localparam int HALF_LEN         = ROW_LEN / 2;
  localparam int IDX_WIDTH        = 3;
  localparam int OPND_WIDTH       = PX_WIDTH + 2;  // holds x_i + x_7-i and x_i - x_7-i.
  localparam int COEF_FRACT_WIDTH = 10;
  localparam int COEF_WIDTH       = 12;
  localparam int PROD_WIDTH       = 22;
  localparam int ACC_WIDTH        = 24;
  localparam int OUT_WIDTH        = 12;

  // products, pair sums, final sum with rounding.
  localparam int MAC_LATENCY      = 3;

  typedef logic        [PX_WIDTH - 1 : 0]   px_t;
  typedef logic signed [OPND_WIDTH - 1 : 0] opnd_t;
  typedef logic signed [COEF_WIDTH - 1 : 0] coef_t;
  typedef logic signed [PROD_WIDTH - 1 : 0] prod_t;
  typedef logic signed [ACC_WIDTH - 1 : 0]  acc_t;
  typedef logic signed [OUT_WIDTH - 1 : 0]  out_t;

  // half of one output step, so ties go towards plus infinity after the shift.
  localparam acc_t ROUND_BIAS = acc_t'( 1 << ( COEF_FRACT_WIDTH - 1 ) );

  // Row k is the output index and column i the butterfly term.
  // Each entry is a_k * cos((2i+1) k pi / 16) scaled by 1024.
  // Even rows weight the sums and odd rows the differences.
  localparam coef_t COEF_TABLE [ROW_LEN][HALF_LEN] = '{
    '{  12'sd362,  12'sd362,  12'sd362,  12'sd362 },
    '{  12'sd502,  12'sd426,  12'sd284,  12'sd100 },
    '{  12'sd473,  12'sd196, -12'sd196, -12'sd473 },
    '{  12'sd426, -12'sd100, -12'sd502, -12'sd284 },
    '{  12'sd362, -12'sd362, -12'sd362,  12'sd362 },
    '{  12'sd284, -12'sd502,  12'sd100,  12'sd426 },
    '{  12'sd196, -12'sd473,  12'sd473, -12'sd196 },
    '{  12'sd100, -12'sd284,  12'sd426, -12'sd502 }
  };

endpackage

`default_nettype wire
